// ==== aux/aux_buffer.sv ====
module aux_buffer #(
	parameter int AUX_DEPTH = 64
) (
	input  logic                     pclk,
	input  logic                     RSTBTN,
	input  logic                     wr_en,
	input  video_pkg::aux_word_t     din,
	input  logic                     rd_en,
	output video_pkg::aux_word_t     head,
	output logic [$clog2(AUX_DEPTH):0] level,
	output logic                     full
);
	import video_pkg::*;

	localparam int PTR_W = $clog2(AUX_DEPTH);

	aux_word_t        mem [AUX_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_wr;
	logic             do_rd;

	assign full  = (level == (PTR_W + 1)'(AUX_DEPTH));
	assign do_wr = wr_en && !full; // Dropped when full
	assign do_rd = rd_en && (level != '0);
	assign head  = mem[rd_ptr];    // Oldest word always on show

	always_ff @(posedge pclk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(AUX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(AUX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: ; // Both or neither
			endcase
		end
	end

endmodule

// ==== aux/aux_island_scheduler.sv ====
module aux_island_scheduler #(
	parameter int ISLAND_LEN = 32,
	parameter int AUX_DEPTH  = 64
) (
	input  logic                       pclk,
	input  logic                       RSTBTN,
	input  video_pkg::coord_t          hcount,
	input  logic                       vde,
	input  logic                       hsync,
	input  logic                       vsync,
	input  video_pkg::aux_word_t       head,
	input  logic [$clog2(AUX_DEPTH):0] level,
	output logic                       ade,
	output video_pkg::aux_nibble_t     aux0,
	output video_pkg::aux_nibble_t     aux1,
	output video_pkg::aux_nibble_t     aux2
);
	import video_pkg::*;

	localparam int CNT_W = $clog2(ISLAND_LEN);
	localparam int LVL_W = $clog2(AUX_DEPTH) + 1;

	typedef enum logic [1:0] {
		WAIT_VIDEO,
		WAIT_COLUMN,
		ISLAND
	} island_state_t;

	island_state_t    state;
	logic [CNT_W-1:0] burst_cnt; // Words sent in this burst
	coord_t           start_col;
	logic             enough;

	assign start_col = head[AUX_COL_LSB +: $bits(coord_t)];
	assign enough    = (level >= LVL_W'(ISLAND_LEN)); // A whole burst is buffered

	////////////////////
	// Burst timing
	////////////////////
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			state     <= WAIT_VIDEO;
			burst_cnt <= '0;
		end else begin
			case (state)
				WAIT_VIDEO: begin
					if (vde) begin
						state <= WAIT_COLUMN;
					end
				end
				WAIT_COLUMN: begin
					// Short buffer skips this line, next line checks again
					if ((hcount == start_col) && enough) begin
						state     <= ISLAND;
						burst_cnt <= '0;
					end
				end
				ISLAND: begin
					burst_cnt <= burst_cnt + 1'b1;
					if (burst_cnt == CNT_W'(ISLAND_LEN - 1)) begin
						state <= WAIT_COLUMN;
					end
				end
				default: state <= WAIT_VIDEO;
			endcase
		end
	end

	assign ade = (state == ISLAND); // Also pops the buffer

	// Lanes carry the word being popped
	assign aux0 = {1'b1, head[0], vsync, hsync};
	assign aux1 = head[4:1];
	assign aux2 = head[8:5];

endmodule

// ==== common/video_pkg.sv ====
package video_pkg;

	typedef logic [10:0] coord_t;    // Pixel or line position
	typedef logic [3:0]  sw_code_t;  // Mode switch code
	typedef logic [23:0] aux_word_t; // Start column on top, payload below
	typedef logic [3:0]  aux_nibble_t;

	localparam int AUX_COL_LSB = 13; // Column field is 23..13

	localparam sw_code_t SW_VGA      = 4'b0000;
	localparam sw_code_t SW_SVGA     = 4'b0001;
	localparam sw_code_t SW_XGA      = 4'b0011;
	localparam sw_code_t SW_HDTV720P = 4'b0010;
	localparam sw_code_t SW_SXGA     = 4'b1000;
	localparam sw_code_t SW_CAMERA   = 4'b1001;

	////////////////////
	// Live area then sync width, front and back porch of each mode
	////////////////////
	localparam coord_t
		HPIXELS_VGA = 11'd640, VLINES_VGA  = 11'd480,
		HSYNCPW_VGA = 11'd96,  VSYNCPW_VGA = 11'd2,
		HFNPRCH_VGA = 11'd16,  VFNPRCH_VGA = 11'd11,
		HBKPRCH_VGA = 11'd48,  VBKPRCH_VGA = 11'd31;

	localparam coord_t
		HPIXELS_SVGA = 11'd800, VLINES_SVGA  = 11'd600,
		HSYNCPW_SVGA = 11'd128, VSYNCPW_SVGA = 11'd4,
		HFNPRCH_SVGA = 11'd40,  VFNPRCH_SVGA = 11'd1,
		HBKPRCH_SVGA = 11'd88,  VBKPRCH_SVGA = 11'd23;

	localparam coord_t
		HPIXELS_XGA = 11'd1024, VLINES_XGA  = 11'd768,
		HSYNCPW_XGA = 11'd136,  VSYNCPW_XGA = 11'd6,
		HFNPRCH_XGA = 11'd24,   VFNPRCH_XGA = 11'd3,
		HBKPRCH_XGA = 11'd160,  VBKPRCH_XGA = 11'd29;

	localparam coord_t
		HPIXELS_HDTV720P = 11'd1280, VLINES_HDTV720P  = 11'd720,
		HSYNCPW_HDTV720P = 11'd40,   VSYNCPW_HDTV720P = 11'd5,
		HFNPRCH_HDTV720P = 11'd110,  VFNPRCH_HDTV720P = 11'd5,
		HBKPRCH_HDTV720P = 11'd220,  VBKPRCH_HDTV720P = 11'd20;

	localparam coord_t
		HPIXELS_SXGA = 11'd1280, VLINES_SXGA  = 11'd1024,
		HSYNCPW_SXGA = 11'd112,  VSYNCPW_SXGA = 11'd3,
		HFNPRCH_SXGA = 11'd48,   VFNPRCH_SXGA = 11'd1,
		HBKPRCH_SXGA = 11'd248,  VBKPRCH_SXGA = 11'd38;

	localparam coord_t
		HPIXELS_CAMERA = 11'd1280, VLINES_CAMERA  = 11'd720,
		HSYNCPW_CAMERA = 11'd39,   VSYNCPW_CAMERA = 11'd4,
		HFNPRCH_CAMERA = 11'd110,  VFNPRCH_CAMERA = 11'd4,
		HBKPRCH_CAMERA = 11'd220,  VBKPRCH_CAMERA = 11'd22;

endpackage

// ==== common/video_timing_if.sv ====
interface video_timing_if;
	import video_pkg::*;

	coord_t hsblnk; // Last live pixel
	coord_t hssync; // Sync starts after this count
	coord_t hesync; // Last sync count
	coord_t heblnk; // Last count of the line
	coord_t vsblnk;
	coord_t vssync;
	coord_t vesync;
	coord_t veblnk;
	logic   sync_neg; // High for negative sync

	modport table_mp (
		output hsblnk, hssync, hesync, heblnk,
		output vsblnk, vssync, vesync, veblnk,
		output sync_neg
	);

	modport gen_mp (
		input hsblnk, hssync, hesync, heblnk,
		input vsblnk, vssync, vesync, veblnk,
		input sync_neg
	);

endinterface

// ==== rtl/sync_output_stage.sv ====
module sync_output_stage (
	input  logic           pclk,
	video_timing_if.gen_mp timing,
	input  logic           hblnk,
	input  logic           vblnk,
	input  logic           hsync_raw,
	input  logic           vsync_raw,
	output logic           hsync,
	output logic           vsync,
	output logic           vde
);

	logic hsync_q;
	logic vsync_q;
	logic active_q;

	// Two stages keep sync and DE aligned
	always_ff @(posedge pclk) begin
		hsync_q  <= hsync_raw ^ timing.sync_neg;
		vsync_q  <= vsync_raw ^ timing.sync_neg;
		active_q <= !hblnk && !vblnk;
		hsync    <= hsync_q;
		vsync    <= vsync_q;
		vde      <= active_q;
	end

endmodule

// ==== rtl/video_aux_top.sv ====
module video_aux_top #(
	parameter int AUX_DEPTH  = 64,
	parameter int ISLAND_LEN = 32
) (
	input  logic                   pclk,
	input  logic                   RSTBTN,
	input  video_pkg::sw_code_t    sw,
	input  logic                   aux_wr_en,
	input  video_pkg::aux_word_t   aux_din,
	output video_pkg::coord_t      hcount,
	output video_pkg::coord_t      vcount,
	output logic                   hsync,
	output logic                   vsync,
	output logic                   vde,
	output logic                   ade,
	output video_pkg::aux_nibble_t aux0,
	output video_pkg::aux_nibble_t aux1,
	output video_pkg::aux_nibble_t aux2,
	output logic                   aux_full
);
	import video_pkg::*;

	video_timing_if timing_bus ();

	logic                       hblnk;
	logic                       vblnk;
	logic                       hsync_raw;
	logic                       vsync_raw;
	aux_word_t                  aux_head;
	logic [$clog2(AUX_DEPTH):0] aux_level;

	////////////////////
	// Video path
	////////////////////
	video_mode_table u_mode_table (
		.pclk   (pclk),
		.RSTBTN (RSTBTN),
		.sw     (sw),
		.timing (timing_bus.table_mp)
	);

	video_timing_gen u_timing_gen (
		.pclk      (pclk),
		.RSTBTN    (RSTBTN),
		.timing    (timing_bus.gen_mp),
		.hcount    (hcount),
		.vcount    (vcount),
		.hblnk     (hblnk),
		.vblnk     (vblnk),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw)
	);

	sync_output_stage u_sync_stage (
		.pclk      (pclk),
		.timing    (timing_bus.gen_mp),
		.hblnk     (hblnk),
		.vblnk     (vblnk),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw),
		.hsync     (hsync),
		.vsync     (vsync),
		.vde       (vde)
	);

	////////////////////
	// Aux path
	////////////////////
	aux_buffer #(
		.AUX_DEPTH (AUX_DEPTH)
	) u_aux_buffer (
		.pclk   (pclk),
		.RSTBTN (RSTBTN),
		.wr_en  (aux_wr_en),
		.din    (aux_din),
		.rd_en  (ade),      // One pop per island cycle
		.head   (aux_head),
		.level  (aux_level),
		.full   (aux_full)
	);

	aux_island_scheduler #(
		.ISLAND_LEN (ISLAND_LEN),
		.AUX_DEPTH  (AUX_DEPTH)
	) u_scheduler (
		.pclk   (pclk),
		.RSTBTN (RSTBTN),
		.hcount (hcount),
		.vde    (vde),
		.hsync  (hsync),
		.vsync  (vsync),
		.head   (aux_head),
		.level  (aux_level),
		.ade    (ade),
		.aux0   (aux0),
		.aux1   (aux1),
		.aux2   (aux2)
	);

endmodule

// ==== rtl/video_mode_table.sv ====
module video_mode_table (
	input  logic                pclk,
	input  logic                RSTBTN,
	input  video_pkg::sw_code_t sw,
	video_timing_if.table_mp    timing
);
	import video_pkg::*;

	sw_code_t sw_meta; // First sync stage
	sw_code_t sw_mode; // Mode in use
	coord_t   hpix;
	coord_t   hfp;
	coord_t   hsw;
	coord_t   hbp;
	coord_t   vlin;
	coord_t   vfp;
	coord_t   vsw;
	coord_t   vbp;
	logic     neg;

	// Counters never restart, so a new mode is only taken while held in reset
	always_ff @(posedge pclk) begin
		sw_meta <= sw;
		if (RSTBTN) begin
			sw_mode <= sw_meta;
		end
	end

	always_comb begin
		{hpix, hfp, hsw, hbp} = {HPIXELS_HDTV720P, HFNPRCH_HDTV720P, HSYNCPW_HDTV720P,
			HBKPRCH_HDTV720P};
		{vlin, vfp, vsw, vbp} = {VLINES_HDTV720P, VFNPRCH_HDTV720P, VSYNCPW_HDTV720P,
			VBKPRCH_HDTV720P};
		neg = 1'b0;
		case (sw_mode)
			SW_VGA: begin
				{hpix, hfp, hsw, hbp} = {HPIXELS_VGA, HFNPRCH_VGA, HSYNCPW_VGA, HBKPRCH_VGA};
				{vlin, vfp, vsw, vbp} = {VLINES_VGA, VFNPRCH_VGA, VSYNCPW_VGA, VBKPRCH_VGA};
				neg = 1'b1;
			end
			SW_SVGA: begin
				{hpix, hfp, hsw, hbp} = {HPIXELS_SVGA, HFNPRCH_SVGA, HSYNCPW_SVGA, HBKPRCH_SVGA};
				{vlin, vfp, vsw, vbp} = {VLINES_SVGA, VFNPRCH_SVGA, VSYNCPW_SVGA, VBKPRCH_SVGA};
			end
			SW_XGA: begin
				{hpix, hfp, hsw, hbp} = {HPIXELS_XGA, HFNPRCH_XGA, HSYNCPW_XGA, HBKPRCH_XGA};
				{vlin, vfp, vsw, vbp} = {VLINES_XGA, VFNPRCH_XGA, VSYNCPW_XGA, VBKPRCH_XGA};
				neg = 1'b1;
			end
			SW_SXGA: begin
				{hpix, hfp, hsw, hbp} = {HPIXELS_SXGA, HFNPRCH_SXGA, HSYNCPW_SXGA, HBKPRCH_SXGA};
				{vlin, vfp, vsw, vbp} = {VLINES_SXGA, VFNPRCH_SXGA, VSYNCPW_SXGA, VBKPRCH_SXGA};
			end
			SW_CAMERA: begin
				{hpix, hfp, hsw, hbp} = {HPIXELS_CAMERA, HFNPRCH_CAMERA, HSYNCPW_CAMERA,
					HBKPRCH_CAMERA};
				{vlin, vfp, vsw, vbp} = {VLINES_CAMERA, VFNPRCH_CAMERA, VSYNCPW_CAMERA,
					VBKPRCH_CAMERA};
			end
			default: ; // 720p values stand
		endcase
	end

	assign timing.hsblnk   = hpix - coord_t'(1);
	assign timing.hssync   = hpix - coord_t'(1) + hfp;
	assign timing.hesync   = hpix - coord_t'(1) + hfp + hsw;
	assign timing.heblnk   = hpix - coord_t'(1) + hfp + hsw + hbp;
	assign timing.vsblnk   = vlin - coord_t'(1);
	assign timing.vssync   = vlin - coord_t'(1) + vfp;
	assign timing.vesync   = vlin - coord_t'(1) + vfp + vsw;
	assign timing.veblnk   = vlin - coord_t'(1) + vfp + vsw + vbp;
	assign timing.sync_neg = neg;

endmodule

// ==== rtl/video_timing_gen.sv ====
module video_timing_gen (
	input  logic              pclk,
	input  logic              RSTBTN,
	video_timing_if.gen_mp    timing,
	output video_pkg::coord_t hcount,
	output video_pkg::coord_t vcount,
	output logic              hblnk,
	output logic              vblnk,
	output logic              hsync_raw,
	output logic              vsync_raw
);
	import video_pkg::*;

	coord_t h_next;
	coord_t v_next;
	logic   line_end;

	assign line_end = (hcount == timing.heblnk);
	assign h_next   = line_end ? '0 : hcount + coord_t'(1);

	always_comb begin
		v_next = vcount;
		if (line_end) begin
			v_next = (vcount == timing.veblnk) ? '0 : vcount + coord_t'(1);
		end
	end

	// Flags come from the next count so they line up with hcount and vcount
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			hcount    <= '0;
			vcount    <= '0;
			hblnk     <= 1'b1; // Blanked while in reset
			vblnk     <= 1'b1;
			hsync_raw <= 1'b0;
			vsync_raw <= 1'b0;
		end else begin
			hcount    <= h_next;
			vcount    <= v_next;
			hblnk     <= (h_next > timing.hsblnk);
			vblnk     <= (v_next > timing.vsblnk);
			hsync_raw <= (h_next > timing.hssync) && (h_next <= timing.hesync);
			vsync_raw <= (v_next > timing.vssync) && (v_next <= timing.vesync);
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_video_aux \
	-f src.f --Mdir obj_dir -o tb_video_aux

./obj_dir/tb_video_aux | tee sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0

// ==== src.f ====
common/video_pkg.sv
common/video_timing_if.sv
rtl/video_mode_table.sv
rtl/video_timing_gen.sv
rtl/sync_output_stage.sv
aux/aux_buffer.sv
aux/aux_island_scheduler.sv
rtl/video_aux_top.sv
test/tb_video_aux.sv

// ==== test/tb_video_aux.sv ====
module tb_video_aux;
	timeunit 1ns;
	timeprecision 100ps;

	import video_pkg::*;

	localparam int AUX_DEPTH  = 64;
	localparam int ISLAND_LEN = 32;
	localparam int SEL_HSYNC  = 0;
	localparam int SEL_VSYNC  = 1;
	localparam int SEL_VDE    = 2;
	localparam int SEL_ADE    = 3;

	logic        pclk;
	logic        RSTBTN;
	sw_code_t    sw;
	logic        aux_wr_en;
	aux_word_t   aux_din;
	coord_t      hcount;
	coord_t      vcount;
	logic        hsync;
	logic        vsync;
	logic        vde;
	logic        ade;
	aux_nibble_t aux0;
	aux_nibble_t aux1;
	aux_nibble_t aux2;
	logic        aux_full;

	logic [31:0] lfsr_state = 32'h1c1dc60e;
	logic [12:0] expected_payloads[$]; // Aux payloads in write order
	int          mismatch_count = 0;
	int          timeout_count = 0;
	int          other_count = 0;

	video_aux_top #(
		.AUX_DEPTH  (AUX_DEPTH),
		.ISLAND_LEN (ISLAND_LEN)
	) DUT (
		.pclk      (pclk),
		.RSTBTN    (RSTBTN),
		.sw        (sw),
		.aux_wr_en (aux_wr_en),
		.aux_din   (aux_din),
		.hcount    (hcount),
		.vcount    (vcount),
		.hsync     (hsync),
		.vsync     (vsync),
		.vde       (vde),
		.ade       (ade),
		.aux0      (aux0),
		.aux1      (aux1),
		.aux2      (aux2),
		.aux_full  (aux_full)
	);

	always #2 pclk = ~pclk;

	////////////////////
	// Checks and helpers
	////////////////////
	task automatic check_coord(input string name, input coord_t got, input coord_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t ns: %s got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_nibble(input string name, input aux_nibble_t got,
		input aux_nibble_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Galois LFSR with one step per payload bit
	function automatic logic [12:0] random_payload();
		logic [12:0] value;
		for (int i = 0; i < 13; i++) begin
			value[i]   = lfsr_state[0];
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
		end
		return value;
	endfunction

	function automatic logic sig_value(input int sel);
		case (sel)
			SEL_HSYNC: return hsync;
			SEL_VSYNC: return vsync;
			SEL_VDE:   return vde;
			default:   return ade;
		endcase
	endfunction

	function automatic string sig_name(input int sel);
		case (sel)
			SEL_HSYNC: return "hsync";
			SEL_VSYNC: return "vsync";
			SEL_VDE:   return "vde";
			default:   return "ade";
		endcase
	endfunction

	// Steps on falling edges until the signal has the level and counts the cycles
	task automatic wait_level(input int sel, input logic level, input int limit,
		output int cycles);
		cycles = 0;
		while (sig_value(sel) !== level) begin
			if (cycles >= limit) begin
				timeout_count++;
				$display("Timeout at %0t ns: %s stayed away from %b for %0d cycles",
					$time, sig_name(sel), level, limit);
				return;
			end
			@(negedge pclk);
			cycles++;
		end
	endtask

	task automatic mode_numbers(input sw_code_t code, output coord_t pix, output coord_t period,
		output coord_t sync_w, output logic neg);
		case (code)
			SW_VGA: begin
				pix    = HPIXELS_VGA;
				sync_w = HSYNCPW_VGA;
				period = HPIXELS_VGA + HFNPRCH_VGA + HSYNCPW_VGA + HBKPRCH_VGA;
				neg    = 1'b1; // Active low syncs
			end
			SW_SVGA: begin
				pix    = HPIXELS_SVGA;
				sync_w = HSYNCPW_SVGA;
				period = HPIXELS_SVGA + HFNPRCH_SVGA + HSYNCPW_SVGA + HBKPRCH_SVGA;
				neg    = 1'b0;
			end
			default: begin
				pix    = HPIXELS_HDTV720P;
				sync_w = HSYNCPW_HDTV720P;
				period = HPIXELS_HDTV720P + HFNPRCH_HDTV720P + HSYNCPW_HDTV720P
					+ HBKPRCH_HDTV720P;
				neg    = 1'b0;
			end
		endcase
	endtask

	// Loads the mode under reset and checks the outputs at its end
	task automatic reset_dut(input sw_code_t code, input logic neg);
		@(posedge pclk);
		#1;
		RSTBTN = 1'b1;
		sw     = code;
		repeat (9) @(posedge pclk);
		@(negedge pclk);
		check_bit("hsync", hsync, neg);
		check_bit("vsync", vsync, neg);
		check_bit("vde", vde, 1'b0);
		check_bit("ade", ade, 1'b0);
		check_bit("aux_full", aux_full, 1'b0);
		check_coord("hcount", hcount, '0);
		check_coord("vcount", vcount, '0);
		@(posedge pclk);
		#1;
		RSTBTN = 1'b0;
	endtask

	task automatic write_words(input int count, input coord_t col, input logic record);
		logic [12:0] payload;
		@(posedge pclk);
		#1;
		for (int i = 0; i < count; i++) begin
			payload   = random_payload();
			aux_din   = {col, payload};
			aux_wr_en = 1'b1;
			if (record) begin
				expected_payloads.push_back(payload);
			end
			@(posedge pclk);
			#1;
		end
		aux_wr_en = 1'b0;
	endtask

	// Burst must follow the cycle with hcount at col and carry the queued payloads
	// Syncs sit at their idle level in the live area where the burst runs
	task automatic verify_burst(input coord_t col, input logic idle_sync, input int limit);
		coord_t      prev_h;
		logic [12:0] p;
		int          cycles;
		cycles = 0;
		prev_h = hcount;
		while (ade !== 1'b1) begin
			if (cycles >= limit) begin
				timeout_count++;
				$display("Timeout at %0t ns: no aux burst within %0d cycles", $time, limit);
				return;
			end
			prev_h = hcount;
			@(negedge pclk);
			cycles++;
		end
		check_coord("hcount before ade", prev_h, col);
		for (int i = 0; i < ISLAND_LEN; i++) begin
			p = expected_payloads.pop_front();
			check_bit("ade", ade, 1'b1);
			check_bit("hsync", hsync, idle_sync);
			check_bit("vsync", vsync, idle_sync);
			check_nibble("aux0", aux0, {1'b1, p[0], idle_sync, idle_sync});
			check_nibble("aux1", aux1, p[4:1]);
			check_nibble("aux2", aux2, p[8:5]);
			@(negedge pclk);
		end
		check_bit("ade", ade, 1'b0); // Burst is over
	endtask

	////////////////////
	// Directed tests
	////////////////////
	task automatic reset_state();
		reset_dut(SW_HDTV720P, 1'b0);
		@(negedge pclk);
		check_coord("hcount", hcount, '0);
		check_coord("vcount", vcount, '0);
		check_bit("vde", vde, 1'b0);
		check_bit("ade", ade, 1'b0);
		@(negedge pclk);
		check_coord("hcount", hcount, coord_t'(1)); // Counting has started
		check_coord("vcount", vcount, '0);
	endtask

	task automatic horizontal_timing(input sw_code_t code);
		coord_t pix;
		coord_t period;
		coord_t sync_w;
		logic   neg;
		int     width;
		int     gap;
		int     skip;
		mode_numbers(code, pix, period, sync_w, neg);
		reset_dut(code, neg);
		wait_level(SEL_HSYNC, neg, period, skip);
		wait_level(SEL_HSYNC, !neg, 2 * period, skip); // Leading edge
		wait_level(SEL_HSYNC, neg, period, width);
		wait_level(SEL_HSYNC, !neg, period, gap);
		check_coord("hsync width", coord_t'(width), sync_w);
		check_coord("line period", coord_t'(width + gap), period);
		wait_level(SEL_VDE, 1'b0, period, skip);
		wait_level(SEL_VDE, 1'b1, 2 * period, skip);
		wait_level(SEL_VDE, 1'b0, period, width);
		check_coord("vde run", coord_t'(width), pix);
	endtask

	task automatic vertical_timing_vga();
		coord_t pix;
		coord_t period;
		coord_t sync_w;
		logic   neg;
		int     cycles;
		int     lines;
		logic   prev_vde;
		mode_numbers(SW_VGA, pix, period, sync_w, neg);
		reset_dut(SW_VGA, neg);
		wait_level(SEL_VSYNC, 1'b0, 450000, cycles);
		wait_level(SEL_VSYNC, 1'b1, 450000, cycles);
		check_coord("vsync width", coord_t'(cycles), coord_t'(VSYNCPW_VGA * period));
		lines    = 0;
		cycles   = 0;
		prev_vde = vde;
		while (vsync !== 1'b0) begin // Count active lines up to the next vsync
			if (cycles >= 450000) begin
				timeout_count++;
				$display("Timeout at %0t ns: no second vsync within a frame", $time);
				break;
			end
			@(negedge pclk);
			cycles++;
			if (vde && !prev_vde) begin
				lines++;
			end
			prev_vde = vde;
		end
		check_coord("active lines", coord_t'(lines), VLINES_VGA);
	endtask

	task automatic aux_burst_at_column();
		reset_dut(SW_VGA, 1'b1);
		expected_payloads.delete();
		write_words(ISLAND_LEN, coord_t'(100), 1'b1);
		verify_burst(coord_t'(100), 1'b1, 1600);
	endtask

	task automatic short_buffer_skip();
		reset_dut(SW_VGA, 1'b1);
		expected_payloads.delete();
		write_words(20, coord_t'(100), 1'b1);
		for (int i = 0; i < 1600; i++) begin // Two VGA lines
			@(negedge pclk);
			if (ade !== 1'b0) begin
				other_count++;
				$display("Error at %0t ns: aux burst started with 20 words buffered", $time);
				break;
			end
		end
		write_words(ISLAND_LEN - 20, coord_t'(100), 1'b1);
		verify_burst(coord_t'(100), 1'b1, 820);
	endtask

	task automatic overflow_drop();
		reset_dut(SW_VGA, 1'b1);
		for (int i = 0; i < 70; i++) begin
			write_words(1, coord_t'(2047), 1'b0); // Column never reached
			if (i == AUX_DEPTH - 2) begin
				check_bit("aux_full", aux_full, 1'b0);
			end
			if (i >= AUX_DEPTH - 1) begin
				check_bit("aux_full", aux_full, 1'b1);
			end
		end
	endtask

	initial begin
		pclk      = 1'b0;
		RSTBTN    = 1'b1;
		sw        = SW_HDTV720P;
		aux_wr_en = 1'b0;
		aux_din   = '0;
		reset_state();
		horizontal_timing(SW_HDTV720P);
		horizontal_timing(SW_VGA);
		horizontal_timing(SW_SVGA);
		vertical_timing_vga();
		aux_burst_at_column();
		short_buffer_skip();
		overflow_drop();
		$display("Mismatches: %0d, timeouts: %0d, other errors: %0d",
			mismatch_count, timeout_count, other_count);
		if (mismatch_count + timeout_count + other_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
